//--- sim.f
source/mask_pkg.sv
source/mask_insn_queue.sv
source/mask_expander.sv
source/mask_strobe_queue.sv
source/mask_unit.sv
bench/mask_unit_tb.sv

//--- bench/mask_unit_tb.sv
`timescale 1ns/1ps

module mask_unit_tb;

  localparam int unsigned NrLanes        = 4;
  localparam int unsigned NrVInsn        = 8;
  localparam int unsigned MaskQueueDepth = 2;
  localparam int unsigned ClkPeriod      = 8;
  localparam int unsigned NumTests       = 8;
  localparam int unsigned MaxBeats       = 256;
  localparam int unsigned WordBits       = NrLanes * 64;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           req_valid_i;
  logic [$clog2(NrVInsn)-1:0]     req_id_i;
  logic [15:0]                    req_vl_i;
  logic [1:0]                     req_vsew_i;
  logic                           req_vm_i;
  logic [NrVInsn-1:0]             req_running_i;
  logic                           req_ready_o;
  logic [NrVInsn-1:0]             done_o;
  logic [NrLanes-1:0][63:0]       mask_operand_i;
  logic [NrLanes-1:0]             mask_operand_valid_i;
  logic [NrLanes-1:0]             mask_operand_ready_o;
  logic [NrLanes-1:0][7:0]        mask_o;
  logic [NrLanes-1:0]             mask_valid_o;
  logic [NrLanes-1:0]             lane_mask_ready_i;
  logic                           vldu_mask_ready_i;
  logic                           vstu_mask_ready_i;

  // Lane words for the current instruction, lane 0 in the low bits
  logic [WordBits-1:0] word_mem [8];
  int                  word_idx;
  // Expected strobes per beat and lane
  logic [7:0]          exp_strb [MaxBeats][NrLanes];
  int                  exp_beats;
  // Lane words the instruction should release
  int                  exp_words;

  // Monitor state
  int                  got_cnt [NrLanes];
  int                  rdy_cnt;
  logic [NrLanes-1:0]  hold_q;
  logic [7:0]          hold_strb [NrLanes];
  logic [NrVInsn-1:0]  model_running;
  logic [$clog2(NrVInsn)-1:0] cur_id;
  logic                busy;
  logic                accept_seen;
  logic                ready_seen;
  logic                lsu_mode;
  int                  accept_cnt;
  int                  done_cnt;
  int                  errors;
  int                  tests_run;
  int                  seed_val;

  mask_unit #(
    .NrLanes        (NrLanes),
    .NrVInsn        (NrVInsn),
    .MaskQueueDepth (MaskQueueDepth)
  ) UUT (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .req_valid_i          (req_valid_i),
    .req_id_i             (req_id_i),
    .req_vl_i             (req_vl_i),
    .req_vsew_i           (req_vsew_i),
    .req_vm_i             (req_vm_i),
    .req_running_i        (req_running_i),
    .req_ready_o          (req_ready_o),
    .done_o               (done_o),
    .mask_operand_i       (mask_operand_i),
    .mask_operand_valid_i (mask_operand_valid_i),
    .mask_operand_ready_o (mask_operand_ready_o),
    .mask_o               (mask_o),
    .mask_valid_o         (mask_valid_o),
    .lane_mask_ready_i    (lane_mask_ready_i),
    .vldu_mask_ready_i    (vldu_mask_ready_i),
    .vstu_mask_ready_i    (vstu_mask_ready_i)
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic report_fail(input string msg);
    $display("Fail %0t: %s", $time, msg);
    errors++;
  endtask

  // Expected strobe beats for one instruction, straight from the expansion rule
  task automatic build_expected(input int vl, input int vsew);
    int ptr;
    int rem;
    int w;
    int e;
    int step;
    ptr       = 0;
    rem       = vl;
    w         = 0;
    step      = (NrLanes * 8) >> vsew;
    exp_beats = 0;
    while (rem > 0) begin
      for (int l = 0; l < NrLanes; l++) begin
        for (int k = 0; k < 8; k++) begin
          e = (l * 8 + k) >> vsew;
          exp_strb[exp_beats][l][k] = (e < rem) ? word_mem[w][ptr + e] : 1'b0;
        end
      end
      exp_beats++;
      ptr += step;
      rem  = (rem > step) ? rem - step : 0;
      // Word used up or tail reached
      if (ptr == WordBits || rem == 0) begin
        w++;
        ptr = 0;
      end
    end
    exp_words = w;
  endtask

  // Issue one masked instruction and wait for its done pulse
  task automatic run_insn(input int id, input int vl, input int vsew);
    int a0;
    int d0;
    int waited;
    for (int w = 0; w < 8; w++) begin
      word_mem[w] = {$urandom, $urandom, $urandom, $urandom,
                     $urandom, $urandom, $urandom, $urandom};
    end
    build_expected(vl, vsew);
    a0 = accept_cnt;
    d0 = done_cnt;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b1;
    req_id_i    = id[$clog2(NrVInsn)-1:0];
    req_vl_i    = vl[15:0];
    req_vsew_i  = vsew[1:0];
    req_vm_i    = 1'b0;
    waited      = 0;
    while (accept_cnt == a0 && waited < 2000) begin
      @(negedge clk_i);
      waited++;
    end
    if (accept_cnt == a0) begin
      $display("Request for ID %0d was never accepted", id);
      errors++;
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    waited      = 0;
    while (done_cnt == d0 && waited < 2000) begin
      @(negedge clk_i);
      waited++;
    end
    if (done_cnt == d0) begin
      $display("ID %0d never signalled done", id);
      errors++;
    end
    // Leave room to catch a second done pulse
    repeat (3) @(posedge clk_i);
  endtask

  // Hold a request that must be refused
  task automatic present_rejected(input int id, input logic vm);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b1;
    req_id_i    = id[$clog2(NrVInsn)-1:0];
    req_vl_i    = 16'd40;
    req_vsew_i  = 2'd0;
    req_vm_i    = vm;
    repeat (6) @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    req_vm_i    = 1'b0;
    repeat (2) @(posedge clk_i);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("Test %0d %s finished, errors so far %0d", tests_run, name, errors);
  endtask

  // Lane model and functional-unit acknowledgments
  initial begin
    mask_operand_i       = '0;
    mask_operand_valid_i = '0;
    lane_mask_ready_i    = '0;
    vldu_mask_ready_i    = 1'b0;
    vstu_mask_ready_i    = 1'b0;
    word_idx             = 0;
    forever begin
      @(posedge clk_i);
      #1;
      // New word after each operand-ready pulse, first word on accept
      if (accept_seen) begin
        word_idx = 0;
      end else if (ready_seen && word_idx < 7) begin
        word_idx++;
      end
      mask_operand_i = word_mem[word_idx];
      for (int l = 0; l < NrLanes; l++) begin
        mask_operand_valid_i[l] = ($urandom_range(3, 0) != 0);
        lane_mask_ready_i[l]    = !lsu_mode && ($urandom_range(1, 0) != 0);
      end
      vldu_mask_ready_i = lsu_mode && ($urandom_range(2, 0) == 0);
      vstu_mask_ready_i = lsu_mode && ($urandom_range(3, 0) == 0);
    end
  end

  // Checks at the falling edge, where every output has settled
  always @(negedge clk_i) begin
    logic ack;
    if (!rst_ni) begin
      busy          = 1'b0;
      model_running = '0;
      accept_seen   = 1'b0;
      ready_seen    = 1'b0;
      hold_q        = '0;
      rdy_cnt       = 0;
    end else begin
      ready_seen = |mask_operand_ready_o;
      // Operand release reaches every lane together
      assert (mask_operand_ready_o == '0 || mask_operand_ready_o == '1)
        else report_fail($sformatf("partial mask_operand_ready_o %b", mask_operand_ready_o));
      if (ready_seen) begin
        rdy_cnt++;
      end
      for (int l = 0; l < NrLanes; l++) begin
        ack = lane_mask_ready_i[l] || vldu_mask_ready_i || vstu_mask_ready_i;
        // Unacknowledged strobes must not move
        if (hold_q[l]) begin
          assert (mask_valid_o[l] && mask_o[l] == hold_strb[l])
            else report_fail($sformatf("lane %0d strobe changed while waiting", l));
        end
        if (mask_valid_o[l] && ack) begin
          assert (got_cnt[l] < exp_beats)
            else report_fail($sformatf("lane %0d delivered an extra beat", l));
          if (got_cnt[l] < exp_beats) begin
            assert (mask_o[l] == exp_strb[got_cnt[l]][l])
              else report_fail($sformatf("lane %0d beat %0d strobe %h, expected %h",
                                         l, got_cnt[l], mask_o[l], exp_strb[got_cnt[l]][l]));
          end
          got_cnt[l]++;
        end
        hold_q[l]    = mask_valid_o[l] && !ack;
        hold_strb[l] = mask_o[l];
      end
      // Done only for the held ID, after every beat went out
      if (done_o != '0) begin
        assert (busy && done_o == (NrVInsn'(1) << cur_id))
          else report_fail($sformatf("unexpected done_o %b", done_o));
        for (int l = 0; l < NrLanes; l++) begin
          assert (got_cnt[l] == exp_beats)
            else report_fail($sformatf("lane %0d got %0d beats, expected %0d",
                                       l, got_cnt[l], exp_beats));
        end
        // One release per lane word, the tail word included
        assert (rdy_cnt == exp_words)
          else report_fail($sformatf("%0d operand releases, expected %0d",
                                     rdy_cnt, exp_words));
        busy = 1'b0;
        done_cnt++;
      end
      assert (req_ready_o == !busy)
        else report_fail($sformatf("req_ready_o is %b while busy is %b", req_ready_o, busy));
      // Request taken this cycle
      accept_seen = req_valid_i && !busy && !req_vm_i &&
                    !model_running[req_id_i] && (req_vl_i != '0);
      if (accept_seen) begin
        busy    = 1'b1;
        cur_id  = req_id_i;
        rdy_cnt = 0;
        for (int l = 0; l < NrLanes; l++) begin
          got_cnt[l] = 0;
        end
        accept_cnt++;
      end
      model_running = model_running & req_running_i;
      if (accept_seen) begin
        model_running[req_id_i] = 1'b1;
      end
    end
  end

  // Watchdog over all tests
  initial begin
    #(NumTests * 2000 * ClkPeriod);
    $display("Timeout: the run did not finish in time");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    seed_val      = $urandom(37328);
    errors        = 0;
    tests_run     = 0;
    accept_cnt    = 0;
    done_cnt      = 0;
    exp_beats     = 0;
    exp_words     = 0;
    lsu_mode      = 1'b0;
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_id_i      = '0;
    req_vl_i      = '0;
    req_vsew_i    = '0;
    req_vm_i      = 1'b0;
    req_running_i = '1;
    for (int w = 0; w < 8; w++) begin
      word_mem[w] = '0;
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Every element width, vl long enough to cross lane words
    for (int s = 0; s < 4; s++) begin
      run_insn(s, 257 + $urandom_range(300, 0), s);
      end_test($sformatf("vsew %0d", s));
    end

    // Single beat with a short tail
    run_insn(4, $urandom_range(3, 1), 0);
    end_test("short vl");

    // Unmasked request is refused
    present_rejected(5, 1'b1);
    end_test("vm set");

    // ID still running is refused, then taken once released
    present_rejected(2, 1'b0);
    @(posedge clk_i);
    #1;
    req_running_i[2] = 1'b0;
    @(posedge clk_i);
    #1;
    req_running_i = '1;
    run_insn(2, 100 + $urandom_range(100, 0), 2);
    end_test("running ID");

    // Load and store units acknowledge every lane
    lsu_mode = 1'b1;
    run_insn(6, 200 + $urandom_range(100, 0), 1);
    lsu_mode = 1'b0;
    end_test("vldu and vstu ack");

    $display("Tests run %0d, failed checks %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- source/mask_unit.sv
`timescale 1ns/1ps

module mask_unit #(
  parameter int unsigned NrLanes        = 4,
  parameter int unsigned NrVInsn        = 8,
  parameter int unsigned MaskQueueDepth = 2
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Sequencer
  input  logic                                          req_valid_i,
  input  logic [$clog2(NrVInsn)-1:0]                    req_id_i,
  input  logic [mask_pkg::VlWidth-1:0]                  req_vl_i,
  input  logic [mask_pkg::VsewWidth-1:0]                req_vsew_i,
  input  logic                                          req_vm_i,
  input  logic [NrVInsn-1:0]                            req_running_i,
  output logic                                          req_ready_o,
  output logic [NrVInsn-1:0]                            done_o,
  // Lanes
  input  logic [NrLanes-1:0][mask_pkg::ElenWidth-1:0]   mask_operand_i,
  input  logic [NrLanes-1:0]                            mask_operand_valid_i,
  output logic [NrLanes-1:0]                            mask_operand_ready_o,
  // Functional units
  output logic [NrLanes-1:0][mask_pkg::StrbWidth-1:0]   mask_o,
  output logic [NrLanes-1:0]                            mask_valid_o,
  input  logic [NrLanes-1:0]                            lane_mask_ready_i,
  input  logic                                          vldu_mask_ready_i,
  input  logic                                          vstu_mask_ready_i
);

  import mask_pkg::*;

  // Instruction queue to expander
  logic                 accept;
  logic                 issue_valid;
  logic [VlWidth-1:0]   issue_vl;
  logic [VsewWidth-1:0] issue_vsew;
  logic                 issue_done;

  // Expander to strobe queue
  logic                               push;
  logic [NrLanes-1:0][StrbWidth-1:0]  push_strb;
  logic                               queue_full;
  logic                               pop;

  mask_insn_queue #(
    .NrLanes (NrLanes),
    .NrVInsn (NrVInsn)
  ) i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_id_i      (req_id_i),
    .req_vl_i      (req_vl_i),
    .req_vsew_i    (req_vsew_i),
    .req_vm_i      (req_vm_i),
    .req_running_i (req_running_i),
    .req_ready_o   (req_ready_o),
    .accept_o      (accept),
    .pop_i         (pop),
    .issue_done_i  (issue_done),
    .issue_valid_o (issue_valid),
    .issue_vl_o    (issue_vl),
    .issue_vsew_o  (issue_vsew),
    .done_o        (done_o)
  );

  mask_expander #(
    .NrLanes (NrLanes)
  ) i_expander (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .accept_i             (accept),
    .issue_valid_i        (issue_valid),
    .issue_vl_i           (issue_vl),
    .issue_vsew_i         (issue_vsew),
    .mask_operand_i       (mask_operand_i),
    .mask_operand_valid_i (mask_operand_valid_i),
    .mask_operand_ready_o (mask_operand_ready_o),
    .queue_full_i         (queue_full),
    .push_o               (push),
    .push_strb_o          (push_strb),
    .issue_done_o         (issue_done)
  );

  mask_strobe_queue #(
    .NrLanes        (NrLanes),
    .MaskQueueDepth (MaskQueueDepth)
  ) i_strobe_queue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .push_i            (push),
    .push_strb_i       (push_strb),
    .mask_o            (mask_o),
    .mask_valid_o      (mask_valid_o),
    .lane_mask_ready_i (lane_mask_ready_i),
    .vldu_mask_ready_i (vldu_mask_ready_i),
    .vstu_mask_ready_i (vstu_mask_ready_i),
    .queue_full_o      (queue_full),
    .pop_o             (pop)
  );

endmodule

//--- source/mask_strobe_queue.sv
`timescale 1ns/1ps

module mask_strobe_queue #(
  parameter int unsigned NrLanes        = 4,
  parameter int unsigned MaskQueueDepth = 2
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Write side, from the expander
  input  logic                                          push_i,
  input  logic [NrLanes-1:0][mask_pkg::StrbWidth-1:0]   push_strb_i,
  // Read side, towards the functional units
  output logic [NrLanes-1:0][mask_pkg::StrbWidth-1:0]   mask_o,
  output logic [NrLanes-1:0]                            mask_valid_o,
  input  logic [NrLanes-1:0]                            lane_mask_ready_i,
  input  logic                                          vldu_mask_ready_i,
  input  logic                                          vstu_mask_ready_i,
  // Status
  output logic                                          queue_full_o,
  output logic                                          pop_o
);

  import mask_pkg::*;

  localparam int unsigned PtrWidth = (MaskQueueDepth > 1) ? $clog2(MaskQueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(MaskQueueDepth + 1);

  // Strobe storage
  logic [MaskQueueDepth-1:0][NrLanes-1:0][StrbWidth-1:0] strb_q;
  // Lanes still waiting for each entry
  logic [MaskQueueDepth-1:0][NrLanes-1:0] valid_d, valid_q;

  logic [PtrWidth-1:0] rd_ptr_d, rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_d, wr_ptr_q;
  logic [CntWidth-1:0] cnt_d, cnt_q;

  logic [NrLanes-1:0] ack;
  logic [NrLanes-1:0] rd_left;

  // Load and store units take every lane in one go
  assign ack = lane_mask_ready_i | {NrLanes{vldu_mask_ready_i | vstu_mask_ready_i}};

  // Head entry, held stable until each lane acknowledges
  assign mask_o       = strb_q[rd_ptr_q];
  assign mask_valid_o = valid_q[rd_ptr_q];

  assign queue_full_o = (cnt_q == CntWidth'(MaskQueueDepth));

  // Lanes of the head entry left after this cycle
  assign rd_left = valid_q[rd_ptr_q] & ~ack;
  // Pop as soon as the last lane lets go
  assign pop_o   = (cnt_q != '0) && (rd_left == '0);

  always_comb begin
    valid_d  = valid_q;
    rd_ptr_d = rd_ptr_q;
    wr_ptr_d = wr_ptr_q;
    cnt_d    = cnt_q;

    valid_d[rd_ptr_q] = rd_left;

    if (pop_o) begin
      if (rd_ptr_q == PtrWidth'(MaskQueueDepth - 1)) begin
        rd_ptr_d = '0;
      end else begin
        rd_ptr_d = rd_ptr_q + 1'b1;
      end
      cnt_d = cnt_d - 1'b1;
    end

    // New entry waits on every lane
    if (push_i) begin
      valid_d[wr_ptr_q] = '1;
      if (wr_ptr_q == PtrWidth'(MaskQueueDepth - 1)) begin
        wr_ptr_d = '0;
      end else begin
        wr_ptr_d = wr_ptr_q + 1'b1;
      end
      cnt_d = cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      rd_ptr_q <= rd_ptr_d;
      wr_ptr_q <= wr_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      strb_q[wr_ptr_q] <= push_strb_i;
    end
  end

endmodule

//--- source/mask_expander.sv
`timescale 1ns/1ps

module mask_expander #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // Instruction from the instruction queue
  input  logic                                           accept_i,
  input  logic                                           issue_valid_i,
  input  logic [mask_pkg::VlWidth-1:0]                   issue_vl_i,
  input  logic [mask_pkg::VsewWidth-1:0]                 issue_vsew_i,
  // Mask words from the lanes, lane 0 in the low bits
  input  logic [NrLanes-1:0][mask_pkg::ElenWidth-1:0]    mask_operand_i,
  input  logic [NrLanes-1:0]                             mask_operand_valid_i,
  output logic [NrLanes-1:0]                             mask_operand_ready_o,
  // Strobe queue side
  input  logic                                           queue_full_i,
  output logic                                           push_o,
  output logic [NrLanes-1:0][mask_pkg::StrbWidth-1:0]    push_strb_o,
  // Last beat of the instruction
  output logic                                           issue_done_o
);

  import mask_pkg::*;

  // Mask bits held by one full lane word
  localparam int unsigned WordBits = NrLanes * ElenWidth;
  localparam int unsigned PtrWidth = $clog2(WordBits) + 1;

  // Next mask bit to use in the current word
  logic [PtrWidth-1:0] ptr_d, ptr_q;
  // Elements issued so far for this instruction
  logic [VlWidth-1:0] issued_d, issued_q;

  logic [VlWidth-1:0]  remaining;
  logic [VlWidth-1:0]  step;
  logic [WordBits-1:0] mask_word;
  logic                beat;
  logic                last;

  // Flat view, lane l starts at bit l*ElenWidth
  assign mask_word = mask_operand_i;

  assign step      = VlWidth'(elems_per_beat(NrLanes, issue_vsew_i));
  assign remaining = issue_vl_i - issued_q;

  // All lanes present a word and there is room downstream
  assign beat = issue_valid_i && (&mask_operand_valid_i) && !queue_full_i;
  // This beat covers the tail of vl
  assign last = (remaining <= step);

  assign push_o       = beat;
  assign issue_done_o = beat && last;

  // Strobe expansion
  always_comb begin : p_expand
    int unsigned elem;
    push_strb_o = '0;
    for (int l = 0; l < NrLanes; l++) begin
      for (int k = 0; k < StrbWidth; k++) begin
        // Sequential byte layout, one mask bit per element
        elem = (l * StrbWidth + k) >> issue_vsew_i;
        // Bytes past vl stay zero
        if (elem < remaining) begin
          push_strb_o[l][k] = mask_word[ptr_q + elem];
        end
      end
    end
  end

  // Pointer and element bookkeeping
  always_comb begin
    ptr_d                = ptr_q;
    issued_d             = issued_q;
    mask_operand_ready_o = '0;

    if (beat) begin
      ptr_d = ptr_q + PtrWidth'(step);
      // Saturate at vl on the final beat
      if (last) begin
        issued_d = issue_vl_i;
      end else begin
        issued_d = issued_q + step;
      end
      // Word used up, or tail reached so release it early
      if (ptr_d == PtrWidth'(WordBits) || last) begin
        mask_operand_ready_o = '1;
        ptr_d                = '0;
      end
    end

    // Start fresh for a new instruction
    if (accept_i) begin
      ptr_d    = '0;
      issued_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q    <= '0;
      issued_q <= '0;
    end else begin
      ptr_q    <= ptr_d;
      issued_q <= issued_d;
    end
  end

endmodule

//--- source/mask_insn_queue.sv
`timescale 1ns/1ps

module mask_insn_queue #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned NrVInsn = 8
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Sequencer request
  input  logic                             req_valid_i,
  input  logic [$clog2(NrVInsn)-1:0]       req_id_i,
  input  logic [mask_pkg::VlWidth-1:0]     req_vl_i,
  input  logic [mask_pkg::VsewWidth-1:0]   req_vsew_i,
  input  logic                             req_vm_i,
  input  logic [NrVInsn-1:0]               req_running_i,
  output logic                             req_ready_o,
  // Accept pulse towards the expander
  output logic                             accept_o,
  // Progress from the strobe queue and the expander
  input  logic                             pop_i,
  input  logic                             issue_done_i,
  // Instruction being issued
  output logic                             issue_valid_o,
  output logic [mask_pkg::VlWidth-1:0]     issue_vl_o,
  output logic [mask_pkg::VsewWidth-1:0]   issue_vsew_o,
  // Per-ID completion pulse
  output logic [NrVInsn-1:0]               done_o
);

  import mask_pkg::*;

  // Instructions the sequencer still considers running
  logic [NrVInsn-1:0] running_d, running_q;

  // Held instruction
  logic [$clog2(NrVInsn)-1:0] id_q;
  logic [VsewWidth-1:0]       vsew_q;
  logic [VlWidth-1:0]         vl_q;

  // Issue phase still open
  logic issue_d, issue_q;
  // Commit phase still open, which also means the slot is taken
  logic commit_d, commit_q;

  // Elements not yet handed out by the strobe queue
  logic [VlWidth-1:0] commit_cnt_d, commit_cnt_q;
  logic [VlWidth-1:0] commit_step;

  logic [NrVInsn-1:0] done_d;

  // Only one instruction at a time
  assign req_ready_o = !commit_q;

  // Masked, free ID, nonempty
  assign accept_o = req_valid_i && req_ready_o && !req_vm_i &&
                    !running_q[req_id_i] && (req_vl_i != '0);

  assign issue_valid_o = issue_q;
  assign issue_vl_o    = vl_q;
  assign issue_vsew_o  = vsew_q;

  // One popped entry covers a full beat of elements
  assign commit_step = VlWidth'(elems_per_beat(NrLanes, vsew_q));

  always_comb begin
    // Drop IDs the sequencer has retired
    running_d    = running_q & req_running_i;
    issue_d      = issue_q;
    commit_d     = commit_q;
    commit_cnt_d = commit_cnt_q;
    done_d       = '0;

    // Expander has sent its last beat
    if (issue_done_i) begin
      issue_d = 1'b0;
    end

    // Account for every entry leaving the strobe queue
    if (pop_i && commit_q) begin
      if (commit_cnt_q <= commit_step) begin
        // Last entry, signal done and free the slot
        commit_cnt_d  = '0;
        commit_d      = 1'b0;
        done_d[id_q]  = 1'b1;
      end else begin
        commit_cnt_d = commit_cnt_q - commit_step;
      end
    end

    // New instruction
    if (accept_o) begin
      running_d[req_id_i] = 1'b1;
      issue_d             = 1'b1;
      commit_d            = 1'b1;
      commit_cnt_d        = req_vl_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q    <= '0;
      issue_q      <= 1'b0;
      commit_q     <= 1'b0;
      commit_cnt_q <= '0;
      done_o       <= '0;
    end else begin
      running_q    <= running_d;
      issue_q      <= issue_d;
      commit_q     <= commit_d;
      commit_cnt_q <= commit_cnt_d;
      // Registered, so done lands the cycle after the final pop
      done_o       <= done_d;
    end
  end

  // Instruction fields, only loaded on accept
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      id_q   <= req_id_i;
      vsew_q <= req_vsew_i;
      vl_q   <= req_vl_i;
    end
  end

endmodule

//--- source/mask_pkg.sv
package mask_pkg;

  // Width of one lane word
  parameter int unsigned ElenWidth = 64;
  // Bytes per lane word, one strobe bit each
  parameter int unsigned StrbWidth = ElenWidth / 8;
  // Vector length field
  parameter int unsigned VlWidth = 16;
  // Element width field
  parameter int unsigned VsewWidth = 2;

  // Element width codes
  parameter logic [VsewWidth-1:0] EW8 = 2'd0;
  parameter logic [VsewWidth-1:0] EW16 = 2'd1;
  parameter logic [VsewWidth-1:0] EW32 = 2'd2;
  parameter logic [VsewWidth-1:0] EW64 = 2'd3;

  // Elements covered by one strobe beat over all lanes
  function automatic int unsigned elems_per_beat(input int unsigned nr_lanes,
                                                 input logic [VsewWidth-1:0] vsew);
    int unsigned bytes;
    int unsigned elems;
    bytes = nr_lanes * StrbWidth;
    case (vsew)
      EW8:  elems = bytes;
      EW16: elems = bytes >> 1;
      EW32: elems = bytes >> 2;
      EW64: elems = bytes >> 3;
      default: elems = bytes >> 3;
    endcase
    return elems;
  endfunction

endpackage
